// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LFLAGS    = --lint-only --timing -Wall
TOP       = dict_search_tb
FILELIST  = dict_search_top.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dict_search_top.f
logic/forth_dict_pkg.sv
logic/dict_ram.sv
logic/search_dispatch.sv
logic/word_search.sv
logic/search_resolve.sv
logic/dict_search_top.sv
verification/dict_search_chk.sv
verification/dict_search_tb.sv

// File: logic/dict_ram.sv
/* single-port byte RAM with registered read */
`timescale 1ns/1ps
`default_nettype none

module dict_ram
    import forth_dict_pkg::*;
(
    input  wire            clk,
    input  wire            we,    // byte write
    input  wire [ASZ-1:0]  a,     // shared read/write address
    input  wire [DSZ-1:0]  vi,    // write data
    output logic [DSZ-1:0] vo     // byte at last cycle's address
);

    logic [DSZ-1:0] mem [2**ASZ];   // one wordlist

    always_ff @(posedge clk) begin
        if (we) begin
            mem[a] <= vi;
        end
        vo <= mem[a];               // read-first
    end

endmodule

`default_nettype wire

// File: logic/dict_search_top.sv
/* dictionary lookup engine top, dispatcher, one search lane per
   wordlist and the result resolver */
`timescale 1ns/1ps
`default_nettype none

module dict_search_top
    import forth_dict_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire [OPW-1:0]   op,
    input  wire [LSZ-1:0]   lane,
    input  wire [ASZ-1:0]   addr,
    input  wire [DSZ-1:0]   data,
    output logic [DSZ-1:0]  rdata,
    output logic            busy,
    output logic            done,
    output logic            hit,
    output logic            imm,
    output logic [ASZ-1:0]  pfa,
    output logic [LSZ-1:0]  found_lane
);

    logic [LANES-1:0]     wr;
    logic [LANES-1:0]     start;
    logic [ASZ-1:0]       waddr;
    logic [DSZ-1:0]       wdata;
    logic [LANES*LKW-1:0] ctx;
    logic [LANES*TIW-1:0] tib_idx;
    logic [LANES*DSZ-1:0] tib_byte;
    logic                 find;
    logic                 rd;
    logic [LSZ-1:0]       rd_lane;
    logic [LANES-1:0]     lane_busy;
    logic [LANES-1:0]     lane_hit;
    logic [LANES-1:0]     lane_imm;
    logic [LANES*ASZ-1:0] lane_pfa;
    logic [LANES*DSZ-1:0] lane_rd_data;

    search_dispatch u_dispatch (
        .clk, .rst, .op, .lane, .addr, .data,
        .tib_idx, .done,                      // done closes the find window
        .wr, .waddr, .wdata, .start, .ctx, .tib_byte,
        .find, .rd, .rd_lane
    );

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        word_search u_search (
            .clk      (clk),
            .rst      (rst),
            .start    (start[g]),
            .ctx      (ctx[g*LKW +: LKW]),
            .wr       (wr[g]),
            .waddr    (waddr),
            .wdata    (wdata),
            .tib_byte (tib_byte[g*DSZ +: DSZ]),
            .tib_idx  (tib_idx[g*TIW +: TIW]),
            .rd_data  (lane_rd_data[g*DSZ +: DSZ]),
            .busy     (lane_busy[g]),
            .hit      (lane_hit[g]),
            .imm      (lane_imm[g]),
            .pfa      (lane_pfa[g*ASZ +: ASZ])
        );
    end

    search_resolve u_resolve (
        .clk, .rst, .find, .rd, .rd_lane,
        .lane_busy, .lane_hit, .lane_imm, .lane_pfa, .lane_rd_data,
        .busy, .done, .hit, .imm, .pfa, .found_lane, .rdata
    );

endmodule

`default_nettype wire

// File: logic/forth_dict_pkg.sv
/* widths, lane count and host op codes for the dictionary search engine,
   plus the count-byte union shared by the search lanes */
`default_nettype none

package forth_dict_pkg;

    localparam int DSZ   = 8;               // byte width
    localparam int ASZ   = 12;              // 4k bytes per lane
    localparam int LANES = 2;               // lane 0 searched first
    localparam int LSZ   = $clog2(LANES);   // lane select width
    localparam int TSZ   = 32;              // count byte + 31 chars
    localparam int TIW   = $clog2(TSZ);     // tib index width
    localparam int LKW   = 16;              // link field width
    localparam int OPW   = 3;               // host op width

    localparam logic [LKW-1:0] LINK_NIL = 16'hffff;  // end of chain

    localparam logic [OPW-1:0] OP_NOP  = 3'd0;
    localparam logic [OPW-1:0] OP_RD   = 3'd1;   // lane byte read
    localparam logic [OPW-1:0] OP_WR   = 3'd2;   // lane byte write
    localparam logic [OPW-1:0] OP_TIB  = 3'd3;   // tib byte at addr index
    localparam logic [OPW-1:0] OP_CTX  = 3'd4;   // lane context from addr
    localparam logic [OPW-1:0] OP_FIND = 3'd5;   // search all lanes

    // count byte of an entry, seen raw or split into its flag fields
    typedef union packed {
        logic [DSZ-1:0] raw;
        struct packed {
            logic           imm;      // immediate word
            logic           smudge;   // hidden, skip on find
            logic           spare;
            logic [TIW-1:0] len;      // name length
        } f;
    } name_hdr_u;

endpackage

`default_nettype wire

// File: logic/search_dispatch.sv
/* host op decoder with the shared tib and the per-lane context registers,
   routes byte traffic to the lanes and launches finds */
`timescale 1ns/1ps
`default_nettype none

module search_dispatch
    import forth_dict_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire [OPW-1:0]        op,        // one-cycle command strobe
    input  wire [LSZ-1:0]        lane,      // target lane for rd/wr/ctx
    input  wire [ASZ-1:0]        addr,
    input  wire [DSZ-1:0]        data,
    input  wire [LANES*TIW-1:0]  tib_idx,   // per-lane tib index
    input  wire                  done,      // find finished, from resolver
    output logic [LANES-1:0]     wr,
    output logic [ASZ-1:0]       waddr,
    output logic [DSZ-1:0]       wdata,
    output logic [LANES-1:0]     start,
    output logic [LANES*LKW-1:0] ctx,
    output logic [LANES*DSZ-1:0] tib_byte,
    output logic                 find,
    output logic                 rd,
    output logic [LSZ-1:0]       rd_lane
);

    logic [DSZ-1:0] tib [TSZ];       // counted string being searched
    logic [LKW-1:0] ctx_r [LANES];   // newest entry per lane
    logic           act;             // find outstanding
    logic           is_rd;
    logic           is_wr;
    logic           is_tib;
    logic           is_ctx;
    logic           is_find;

    always_comb begin
        is_rd   = 1'b0;
        is_wr   = 1'b0;
        is_tib  = 1'b0;
        is_ctx  = 1'b0;
        is_find = 1'b0;
        case (op)
        OP_NOP:  ;
        OP_RD:   is_rd   = !act;    // everything dropped during a find
        OP_WR:   is_wr   = !act;
        OP_TIB:  is_tib  = !act;
        OP_CTX:  is_ctx  = !act;
        OP_FIND: is_find = !act;
        default: ;
        endcase
    end

    assign waddr   = addr;           // same address to every lane
    assign wdata   = data;
    assign find    = is_find;
    assign rd      = is_rd;
    assign rd_lane = lane;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            wr[i]                 = is_wr && (lane == LSZ'(i));
            start[i]              = is_find;          // all lanes together
            ctx[i*LKW +: LKW]     = ctx_r[i];
            tib_byte[i*DSZ +: DSZ] = tib[tib_idx[i*TIW +: TIW]];  // async lookup
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            act <= 1'b0;
            for (int i = 0; i < LANES; i++) begin
                ctx_r[i] <= LINK_NIL;   // empty wordlists
            end
            for (int t = 0; t < TSZ; t++) begin
                tib[t] <= '0;
            end
        end else begin
            if (is_find) begin
                act <= 1'b1;
            end else if (done) begin
                act <= 1'b0;
            end
            if (is_ctx) begin
                ctx_r[lane] <= LKW'(addr);  // zero-extended entry address
            end
            if (is_tib) begin
                tib[addr[TIW-1:0]] <= data;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/search_resolve.sv
/* waits for every lane to finish, picks the earliest hit in search order
   and registers the read byte of the addressed lane */
`timescale 1ns/1ps
`default_nettype none

module search_resolve
    import forth_dict_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  find,
    input  wire                  rd,
    input  wire [LSZ-1:0]        rd_lane,
    input  wire [LANES-1:0]      lane_busy,
    input  wire [LANES-1:0]      lane_hit,
    input  wire [LANES-1:0]      lane_imm,
    input  wire [LANES*ASZ-1:0]  lane_pfa,
    input  wire [LANES*DSZ-1:0]  lane_rd_data,
    output logic                 busy,
    output logic                 done,
    output logic                 hit,
    output logic                 imm,
    output logic [ASZ-1:0]       pfa,
    output logic [LSZ-1:0]       found_lane,
    output logic [DSZ-1:0]       rdata
);

    logic           pending;     // find in flight
    logic           rd_q;        // RAM byte arrives this cycle
    logic [LSZ-1:0] rd_lane_q;
    logic [LSZ-1:0] sel;         // lowest lane with a hit
    logic           sel_hit;

    always_comb begin
        sel     = '0;
        sel_hit = 1'b0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (lane_hit[i]) begin
                sel     = LSZ'(i);   // lower lane overrides
                sel_hit = 1'b1;
            end
        end
    end

    assign busy = pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            done    <= 1'b0;
            hit     <= 1'b0;
            rd_q    <= 1'b0;
        end else begin
            done <= 1'b0;
            rd_q <= rd;
            if (find) begin
                pending <= 1'b1;     // lanes are busy from next cycle
            end else if (pending && !(|lane_busy)) begin
                pending    <= 1'b0;
                done       <= 1'b1;
                hit        <= sel_hit;
                imm        <= lane_imm[sel];
                pfa        <= lane_pfa[sel*ASZ +: ASZ];
                found_lane <= sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_lane_q <= rd_lane;
        if (rd_q) begin
            rdata <= lane_rd_data[rd_lane_q*DSZ +: DSZ];  // hold until next read
        end
    end

endmodule

`default_nettype wire

// File: logic/word_search.sv
/* one search lane, walks a linked wordlist in its own byte RAM
   and compares each visible name against the tib */
`timescale 1ns/1ps
`default_nettype none

module word_search
    import forth_dict_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             start,      // begin a walk from ctx
    input  wire [LKW-1:0]   ctx,        // newest entry of this wordlist
    input  wire             wr,         // host byte write
    input  wire [ASZ-1:0]   waddr,      // host address while idle
    input  wire [DSZ-1:0]   wdata,
    input  wire [DSZ-1:0]   tib_byte,   // tib[tib_idx], combinational
    output logic [TIW-1:0]  tib_idx,
    output logic [DSZ-1:0]  rd_data,    // raw RAM output
    output logic            busy,
    output logic            hit,
    output logic            imm,
    output logic [ASZ-1:0]  pfa
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_LNK_LO = 3'd1;   // present link low addr
    localparam logic [2:0] S_LNK_HI = 3'd2;   // present link high addr
    localparam logic [2:0] S_COUNT  = 3'd3;   // present count addr
    localparam logic [2:0] S_CMP    = 3'd4;   // count check, then name bytes
    localparam logic [2:0] S_NEXT   = 3'd5;   // follow link or stop

    logic [2:0]     st;
    logic [ASZ-1:0] a;         // walk pointer
    logic [LKW-1:0] lnk;       // link of entry under test
    logic [ASZ-1:0] pfa_r;     // just past the last name byte
    logic           ent_imm;   // imm of entry under test
    logic [ASZ-1:0] ram_a;
    logic [DSZ-1:0] vo;
    name_hdr_u      hdr;

    assign ram_a   = (st == S_IDLE) ? waddr : a;   // host owns the RAM when idle
    assign hdr.raw = vo;
    assign rd_data = vo;

    dict_ram u_ram (
        .clk (clk),
        .we  (wr && (st == S_IDLE)),
        .a   (ram_a),
        .vi  (wdata),
        .vo  (vo)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            st      <= S_IDLE;
            busy    <= 1'b0;
            hit     <= 1'b0;
            tib_idx <= '0;
        end else begin
            case (st)
            S_IDLE: if (start) begin
                lnk  <= ctx;        // treat ctx as a link to chase
                busy <= 1'b1;
                hit  <= 1'b0;
                st   <= S_NEXT;
            end
            S_NEXT: if (lnk == LINK_NIL) begin
                busy <= 1'b0;       // chain ended, miss
                st   <= S_IDLE;
            end else begin
                a  <= lnk[ASZ-1:0];
                st <= S_LNK_LO;
            end
            S_LNK_LO: begin
                a  <= a + 1'b1;
                st <= S_LNK_HI;
            end
            S_LNK_HI: begin
                lnk[DSZ-1:0] <= vo;  // low byte first
                a            <= a + 1'b1;
                st           <= S_COUNT;
            end
            S_COUNT: begin
                lnk[LKW-1:DSZ] <= vo;
                a              <= a + 1'b1;  // first name byte
                tib_idx        <= '0;        // tib count goes first
                st             <= S_CMP;
            end
            S_CMP: if (tib_idx == '0) begin
                // vo is the count byte here, tib_byte the tib count
                if (hdr.f.smudge || (DSZ'(hdr.f.len) != tib_byte)) begin
                    st <= S_NEXT;
                end else if (hdr.f.len == '0) begin
                    hit  <= 1'b1;            // empty name, matches empty tib
                    imm  <= hdr.f.imm;
                    pfa  <= a;
                    busy <= 1'b0;
                    st   <= S_IDLE;
                end else begin
                    ent_imm <= hdr.f.imm;
                    pfa_r   <= a + ASZ'(hdr.f.len);
                    a       <= a + 1'b1;
                    tib_idx <= tib_idx + 1'b1;
                end
            end else if (vo != tib_byte) begin
                st <= S_NEXT;                // mismatch, next entry
            end else if (a == pfa_r) begin
                hit  <= 1'b1;                // last byte equal
                imm  <= ent_imm;
                pfa  <= pfa_r;
                busy <= 1'b0;
                st   <= S_IDLE;
            end else begin
                a       <= a + 1'b1;
                tib_idx <= tib_idx + 1'b1;
            end
            default: st <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/dict_search_chk.sv
/* protocol assertions on the search engine top level,
   bound into dict_search_top */
`timescale 1ns/1ps
`default_nettype none

module dict_search_chk
    import forth_dict_pkg::*;
(
    input wire           clk,
    input wire           rst,
    input wire [OPW-1:0] op,     // host command
    input wire           busy,   // find in flight
    input wire           done    // find finished
);

    int fails = 0;   // property failures so far

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else begin
            fails++;
            $error("done stayed high for more than one cycle");
        end

    // an accepted find raises busy on the very next cycle
    a_find_busy: assert property (@(posedge clk) disable iff (rst)
        (op == OP_FIND && !busy && !done) |=> busy)
        else begin
            fails++;
            $error("busy did not rise one cycle after a find");
        end

    a_busy_src: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> ($past(op) == OP_FIND))   // only a find starts a search
        else begin
            fails++;
            $error("busy rose without a preceding find");
        end

endmodule

bind dict_search_top dict_search_chk u_chk (
    .clk  (clk),
    .rst  (rst),
    .op   (op),
    .busy (busy),
    .done (done)
);

`default_nettype wire

// File: verification/dict_search_tb.sv
/* testbench for the dictionary search engine with random wordlists,
   byte read-back and find checks against a byte-level model */
`timescale 1ns/1ps
`default_nettype none

module dict_search_tb
    import forth_dict_pkg::*;
();

    localparam int NENT  = 6;                    // entries per wordlist
    localparam int NFIND = 40;                   // random finds
    localparam int LIMIT = NFIND * 600 + 3000;   // finds plus setup traffic

    logic           clk = 1'b0;
    logic           rst;
    logic [OPW-1:0] op;
    logic [LSZ-1:0] lane;
    logic [ASZ-1:0] addr;
    logic [DSZ-1:0] data;
    logic [DSZ-1:0] rdata;
    logic           busy;
    logic           done;
    logic           hit;
    logic           imm;
    logic [ASZ-1:0] pfa;
    logic [LSZ-1:0] found_lane;

    logic [DSZ-1:0] mdl [LANES][2**ASZ];   // model copy of each lane RAM
    logic [LKW-1:0] mctx [LANES];          // model contexts
    int             ent_a [LANES][NENT];   // entry start, oldest first
    int             top_a [LANES];         // one past the newest entry
    logic [DSZ-1:0] q [TSZ];               // query, count byte first
    int             errors = 0;
    int             checks = 0;
    int             cycles = 0;

    dict_search_top dut0 (
        .clk, .rst, .op, .lane, .addr, .data,
        .rdata, .busy, .done, .hit, .imm, .pfa, .found_lane
    );

    always #20 clk = ~clk;   // 40 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout, run went past %0d cycles", LIMIT);
            $display("checks %0d errors %0d", checks, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    // one host command, entered 2 ns after a rising edge
    task automatic issue(logic [OPW-1:0] o, int l, int a, logic [DSZ-1:0] d);
        op   = o;
        lane = LSZ'(l);
        addr = ASZ'(a);
        data = d;
        @(posedge clk);     // command sampled here
        #2;
        op = OP_NOP;
    endtask

    task automatic check_eq(string name, logic [31:0] exp, logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            errors++;
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic write_byte(int l, int a, logic [DSZ-1:0] d);
        issue(OP_WR, l, a, d);
        mdl[l][a] = d;
    endtask

    function automatic logic [DSZ-1:0] letter();
        return DSZ'(8'h61 + $urandom_range(1, 0));   // a or b, so names repeat
    endfunction

    // chain of entries, each linked to the one before
    task automatic build_lane(int l);
        logic [LKW-1:0] prev;
        logic [DSZ-1:0] cnt;
        int             a;
        int             n;
        prev = LINK_NIL;                 // oldest entry ends the chain
        a    = $urandom_range(3900, 0);
        for (int k = 0; k < NENT; k++) begin
            n           = $urandom_range(6, 1);
            cnt         = DSZ'(n);
            cnt[7]      = 1'($urandom_range(1, 0));       // immediate
            cnt[6]      = ($urandom_range(3, 0) == 0);    // smudged, one in four
            ent_a[l][k] = a;
            write_byte(l, a, prev[7:0]);                  // link low first
            write_byte(l, a + 1, prev[15:8]);
            write_byte(l, a + 2, cnt);
            for (int i = 1; i <= n; i++) begin
                write_byte(l, a + 2 + i, letter());
            end
            prev = LKW'(a);
            a    = a + 3 + n;            // next entry right at this pfa
        end
        top_a[l] = a;
    endtask

    // fills q with a query and returns its length
    function automatic int make_query();
        int l;
        int e;
        int n;
        l = $urandom_range(LANES - 1, 0);
        e = ent_a[l][$urandom_range(NENT - 1, 0)];
        n = int'(mdl[l][e + 2][4:0]);
        for (int i = 1; i <= n; i++) begin
            q[i] = mdl[l][e + 2 + i];
        end
        case ($urandom_range(3, 0))
        0: ;                                // name taken as is
        1: begin                            // fresh random name
            n = $urandom_range(6, 1);
            for (int i = 1; i <= n; i++) begin
                q[i] = letter();
            end
        end
        2: if (n > 1) begin
            n = n - 1;                      // prefix of an entry
        end
        default: q[n] = (q[n] == 8'h61) ? 8'h62 : 8'h61;   // last byte flipped
        endcase
        q[0] = DSZ'(n);
        return n;
    endfunction

    task automatic load_tib(int n);
        for (int i = 0; i <= n; i++) begin
            issue(OP_TIB, 0, i, q[i]);
        end
    endtask

    // lane 0 first, newest entry first, smudged entries skipped
    function automatic void model_find(output logic h, output logic im,
                                       output int p, output int fl);
        logic [LKW-1:0] lk;
        logic           ok;
        int             e;
        int             n;
        h  = 1'b0;
        im = 1'b0;
        p  = 0;
        fl = 0;
        for (int l = 0; l < LANES && !h; l++) begin
            lk = mctx[l];
            while (lk != LINK_NIL && !h) begin
                e  = int'(lk);
                n  = int'(mdl[l][e + 2][4:0]);
                ok = !mdl[l][e + 2][6] && (DSZ'(n) == q[0]);   // visible, same length
                for (int i = 1; i <= n && ok; i++) begin
                    ok = (mdl[l][e + 2 + i] == q[i]);
                end
                if (ok) begin
                    h  = 1'b1;
                    im = mdl[l][e + 2][7];
                    p  = e + 3 + n;          // byte after the name
                    fl = l;
                end
                lk = {mdl[l][e + 1], mdl[l][e]};
            end
        end
    endfunction

    // rdata lands two edges after the command is driven
    task automatic read_check(int l, int a);
        issue(OP_RD, l, a, '0);
        @(posedge clk);
        #2;
        check_eq("rdata", 32'(mdl[l][a]), 32'(rdata));
    endtask

    task automatic find_check();
        logic eh;
        logic ei;
        int   ep;
        int   el;
        model_find(eh, ei, ep, el);
        issue(OP_FIND, 0, 0, '0);
        check_eq("busy", 1, 32'(busy));   // up one cycle after the find
        do begin
            @(negedge clk);
        end while (done !== 1'b1);
        check_eq("busy", 0, 32'(busy));   // falls with done
        check_eq("hit", 32'(eh), 32'(hit));
        if (eh) begin
            check_eq("pfa", ep, 32'(pfa));
            check_eq("imm", 32'(ei), 32'(imm));
            check_eq("found_lane", el, 32'(found_lane));
        end
        @(posedge clk);                   // dispatcher reopens here
        #2;
    endtask

    initial begin
        int l;
        void'($urandom(32'h58ca));        // fixed seed for the whole run
        rst  = 1'b1;
        op   = OP_NOP;
        lane = '0;
        addr = '0;
        data = '0;
        for (int i = 0; i < LANES; i++) begin
            mctx[i] = LINK_NIL;
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            build_lane(i);
        end
        load_tib(make_query());           // no context yet, so a miss
        find_check();
        repeat (24) begin
            l = $urandom_range(LANES - 1, 0);
            read_check(l, $urandom_range(top_a[l] - 1, ent_a[l][0]));
        end
        for (int i = 0; i < LANES; i++) begin
            issue(OP_CTX, i, ent_a[i][NENT - 1], '0);   // newest entry
            mctx[i] = LKW'(ent_a[i][NENT - 1]);
        end
        repeat (NFIND) begin
            load_tib(make_query());
            find_check();
        end
        errors = errors + dut0.u_chk.fails;   // bound protocol properties
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
